// ==== verilog/mci_pkg.sv ====
// Register map, widths and boot state encoding shared by the MCI RTL and its testbench
package mci_pkg;

    // Register port and watchdog sizes
    localparam int DATA_W       = 32;
    localparam int ADDR_W       = 12;
    localparam int WDT_PERIOD_W = 64;

    // Firmware MCU reset hold, counter wide enough for the hold count
    localparam int MCU_RST_HOLD_CYCLES = 16;
    localparam int MCU_RST_CNT_W       = 5;

    // Register byte offsets
    localparam logic [ADDR_W-1:0] REG_BOOT_GO        = 12'h000;
    localparam logic [ADDR_W-1:0] REG_RESET_REQUEST  = 12'h004;
    localparam logic [ADDR_W-1:0] REG_ERR_FATAL      = 12'h010;
    localparam logic [ADDR_W-1:0] REG_ERR_NON_FATAL  = 12'h014;
    localparam logic [ADDR_W-1:0] REG_WDT_STATUS     = 12'h020;
    localparam logic [ADDR_W-1:0] REG_WDT_T1_EN      = 12'h024;
    localparam logic [ADDR_W-1:0] REG_WDT_T1_RESTART = 12'h028;
    localparam logic [ADDR_W-1:0] REG_WDT_T1_PERIOD0 = 12'h02C;
    localparam logic [ADDR_W-1:0] REG_WDT_T1_PERIOD1 = 12'h030;
    localparam logic [ADDR_W-1:0] REG_WDT_T2_EN      = 12'h034;
    localparam logic [ADDR_W-1:0] REG_WDT_T2_RESTART = 12'h038;
    localparam logic [ADDR_W-1:0] REG_WDT_T2_PERIOD0 = 12'h03C;
    localparam logic [ADDR_W-1:0] REG_WDT_T2_PERIOD1 = 12'h040;
    localparam logic [ADDR_W-1:0] REG_GENERIC_IN0    = 12'h050;
    localparam logic [ADDR_W-1:0] REG_GENERIC_IN1    = 12'h054;
    localparam logic [ADDR_W-1:0] REG_GENERIC_OUT0   = 12'h058;
    localparam logic [ADDR_W-1:0] REG_GENERIC_OUT1   = 12'h05C;
    localparam logic [ADDR_W-1:0] REG_BOOT_STATUS    = 12'h060;

    // Boot sequencer states, readable through REG_BOOT_STATUS
    typedef enum logic [2:0] {
        BOOT_IDLE     = 3'd0,
        BOOT_LCC_INIT = 3'd1,
        BOOT_FC_INIT  = 3'd2,
        BOOT_WAIT_GO  = 3'd3,
        BOOT_DONE     = 3'd4,
        BOOT_MCU_RST  = 3'd5
    } boot_state_e;

endpackage

// ==== verilog/mci_reg_bank.sv ====
// MCI control and status registers behind a strobe access port with a one-cycle read response
`timescale 1ns/1ps

module mci_reg_bank (
    input  logic                             clk,
    input  logic                             rst_i,
    input  logic                             req_i,
    input  logic                             write_i,
    input  logic [mci_pkg::ADDR_W-1:0]       addr_i,
    input  logic [mci_pkg::DATA_W-1:0]       wdata_i,
    output logic [mci_pkg::DATA_W-1:0]       rdata_o,
    output logic                             err_o,
    input  logic [2*mci_pkg::DATA_W-1:0]     generic_in_i,
    output logic [2*mci_pkg::DATA_W-1:0]     generic_out_o,
    input  mci_pkg::boot_state_e             boot_state_i,
    input  logic                             t1_timeout_i,
    input  logic                             t2_timeout_i,
    input  logic [mci_pkg::DATA_W-1:0]       err_fatal_i,
    input  logic [mci_pkg::DATA_W-1:0]       err_non_fatal_i,
    output logic                             boot_go_o,
    output logic                             mcu_rst_req_o,
    output logic                             t1_en_o,
    output logic                             t2_en_o,
    output logic [mci_pkg::WDT_PERIOD_W-1:0] t1_period_o,
    output logic [mci_pkg::WDT_PERIOD_W-1:0] t2_period_o,
    output logic                             t1_restart_o,
    output logic                             t2_restart_o,
    output logic                             t1_serviced_o,
    output logic                             t2_serviced_o,
    output logic [mci_pkg::DATA_W-1:0]       err_fatal_clr_o,
    output logic [mci_pkg::DATA_W-1:0]       err_non_fatal_clr_o
);

    logic                       wr_en;
    logic                       mapped;
    logic [mci_pkg::DATA_W-1:0] rd_data;
    logic sel_boot_go, sel_rst_req, sel_err_fatal, sel_err_nf, sel_wdt_status;
    logic sel_t1_en, sel_t1_restart, sel_t1_p0, sel_t1_p1;
    logic sel_t2_en, sel_t2_restart, sel_t2_p0, sel_t2_p1;
    logic sel_gout0, sel_gout1;

    assign wr_en = req_i & write_i;

    // Single offset decode feeds both the write selects and the read mux
    always_comb begin
        rd_data = '0;
        mapped  = 1'b1;
        {sel_boot_go, sel_rst_req, sel_err_fatal, sel_err_nf, sel_wdt_status} = '0;
        {sel_t1_en, sel_t1_restart, sel_t1_p0, sel_t1_p1} = '0;
        {sel_t2_en, sel_t2_restart, sel_t2_p0, sel_t2_p1, sel_gout0, sel_gout1} = '0;
        case (addr_i)
            mci_pkg::REG_BOOT_GO: begin
                sel_boot_go = 1'b1;
                rd_data[0]  = boot_go_o;
            end
            mci_pkg::REG_RESET_REQUEST: sel_rst_req = 1'b1;
            mci_pkg::REG_ERR_FATAL: begin
                sel_err_fatal = 1'b1;
                rd_data       = err_fatal_i;
            end
            mci_pkg::REG_ERR_NON_FATAL: begin
                sel_err_nf = 1'b1;
                rd_data    = err_non_fatal_i;
            end
            mci_pkg::REG_WDT_STATUS: begin
                sel_wdt_status = 1'b1;
                rd_data[1:0]   = {t2_timeout_i, t1_timeout_i};
            end
            mci_pkg::REG_WDT_T1_EN: begin
                sel_t1_en  = 1'b1;
                rd_data[0] = t1_en_o;
            end
            mci_pkg::REG_WDT_T1_RESTART: sel_t1_restart = 1'b1;
            mci_pkg::REG_WDT_T1_PERIOD0: begin
                sel_t1_p0 = 1'b1;
                rd_data   = t1_period_o[mci_pkg::DATA_W-1:0];
            end
            mci_pkg::REG_WDT_T1_PERIOD1: begin
                sel_t1_p1 = 1'b1;
                rd_data   = t1_period_o[mci_pkg::WDT_PERIOD_W-1:mci_pkg::DATA_W];
            end
            mci_pkg::REG_WDT_T2_EN: begin
                sel_t2_en  = 1'b1;
                rd_data[0] = t2_en_o;
            end
            mci_pkg::REG_WDT_T2_RESTART: sel_t2_restart = 1'b1;
            mci_pkg::REG_WDT_T2_PERIOD0: begin
                sel_t2_p0 = 1'b1;
                rd_data   = t2_period_o[mci_pkg::DATA_W-1:0];
            end
            mci_pkg::REG_WDT_T2_PERIOD1: begin
                sel_t2_p1 = 1'b1;
                rd_data   = t2_period_o[mci_pkg::WDT_PERIOD_W-1:mci_pkg::DATA_W];
            end
            mci_pkg::REG_GENERIC_IN0: rd_data = generic_in_i[mci_pkg::DATA_W-1:0];
            mci_pkg::REG_GENERIC_IN1: rd_data = generic_in_i[2*mci_pkg::DATA_W-1:mci_pkg::DATA_W];
            mci_pkg::REG_GENERIC_OUT0: begin
                sel_gout0 = 1'b1;
                rd_data   = generic_out_o[mci_pkg::DATA_W-1:0];
            end
            mci_pkg::REG_GENERIC_OUT1: begin
                sel_gout1 = 1'b1;
                rd_data   = generic_out_o[2*mci_pkg::DATA_W-1:mci_pkg::DATA_W];
            end
            mci_pkg::REG_BOOT_STATUS: rd_data[$bits(mci_pkg::boot_state_e)-1:0] = boot_state_i;
            default: mapped = 1'b0;
        endcase
    end

    // Control registers
    always_ff @(posedge clk) begin
        if (rst_i) begin
            boot_go_o     <= 1'b0;
            t1_en_o       <= 1'b0;
            t2_en_o       <= 1'b0;
            t1_period_o   <= '0;
            t2_period_o   <= '0;
            generic_out_o <= '0;
        end else if (wr_en) begin
            if (sel_boot_go) boot_go_o <= wdata_i[0];
            if (sel_t1_en) t1_en_o <= wdata_i[0];
            if (sel_t2_en) t2_en_o <= wdata_i[0];
            if (sel_t1_p0) t1_period_o[mci_pkg::DATA_W-1:0] <= wdata_i;
            if (sel_t1_p1) t1_period_o[mci_pkg::WDT_PERIOD_W-1:mci_pkg::DATA_W] <= wdata_i;
            if (sel_t2_p0) t2_period_o[mci_pkg::DATA_W-1:0] <= wdata_i;
            if (sel_t2_p1) t2_period_o[mci_pkg::WDT_PERIOD_W-1:mci_pkg::DATA_W] <= wdata_i;
            if (sel_gout0) generic_out_o[mci_pkg::DATA_W-1:0] <= wdata_i;
            if (sel_gout1) generic_out_o[2*mci_pkg::DATA_W-1:mci_pkg::DATA_W] <= wdata_i;
        end
    end

    // Write-1 pulses and clear masks, seen on the same edge as the write
    assign mcu_rst_req_o       = wr_en & sel_rst_req & wdata_i[0];
    assign t1_restart_o        = wr_en & sel_t1_restart & wdata_i[0];
    assign t2_restart_o        = wr_en & sel_t2_restart & wdata_i[0];
    assign t1_serviced_o       = wr_en & sel_wdt_status & wdata_i[0];
    assign t2_serviced_o       = wr_en & sel_wdt_status & wdata_i[1];
    assign err_fatal_clr_o     = (wr_en & sel_err_fatal) ? wdata_i : '0;
    assign err_non_fatal_clr_o = (wr_en & sel_err_nf) ? wdata_i : '0;

    // Response held until the next request
    always_ff @(posedge clk) begin
        if (rst_i) begin
            rdata_o <= '0;
            err_o   <= 1'b0;
        end else if (req_i) begin
            rdata_o <= rd_data;
            err_o   <= ~mapped;
        end
    end

endmodule

// ==== verilog/mci_boot_seqr.sv ====
// Boot sequencer; steps lifecycle and fuse init, releases MCU then Caliptra, handles MCU reset
`timescale 1ns/1ps

module mci_boot_seqr (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 lc_done_i,
    input  logic                 fc_opt_done_i,
    input  logic                 boot_go_i,
    input  logic                 mcu_rst_req_i,
    output logic                 lc_init_o,
    output logic                 fc_opt_init_o,
    output logic                 mcu_rst_b_o,
    output logic                 cptra_rst_b_o,
    output mci_pkg::boot_state_e boot_state_o
);

    mci_pkg::boot_state_e              state_q;
    mci_pkg::boot_state_e              state_d;
    logic [mci_pkg::MCU_RST_CNT_W-1:0] hold_cnt_q;
    logic                              hold_done;

    assign hold_done    = (int'(hold_cnt_q) == mci_pkg::MCU_RST_HOLD_CYCLES - 1);
    assign boot_state_o = state_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            mci_pkg::BOOT_IDLE: state_d = mci_pkg::BOOT_LCC_INIT;
            mci_pkg::BOOT_LCC_INIT: if (lc_done_i) state_d = mci_pkg::BOOT_FC_INIT;
            mci_pkg::BOOT_FC_INIT: if (fc_opt_done_i) state_d = mci_pkg::BOOT_WAIT_GO;
            mci_pkg::BOOT_WAIT_GO: if (boot_go_i) state_d = mci_pkg::BOOT_DONE;
            // Firmware reset requests only count once boot has finished
            mci_pkg::BOOT_DONE: if (mcu_rst_req_i) state_d = mci_pkg::BOOT_MCU_RST;
            mci_pkg::BOOT_MCU_RST: if (hold_done) state_d = mci_pkg::BOOT_DONE;
            default: state_d = mci_pkg::BOOT_IDLE;
        endcase
    end

    // Outputs decoded from the next state so they change with the state
    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q       <= mci_pkg::BOOT_IDLE;
            lc_init_o     <= 1'b0;
            fc_opt_init_o <= 1'b0;
            mcu_rst_b_o   <= 1'b0;
            cptra_rst_b_o <= 1'b0;
            hold_cnt_q    <= '0;
        end else begin
            state_q       <= state_d;
            lc_init_o     <= (state_d == mci_pkg::BOOT_LCC_INIT);
            fc_opt_init_o <= (state_d == mci_pkg::BOOT_FC_INIT);
            mcu_rst_b_o   <= (state_d == mci_pkg::BOOT_WAIT_GO) ||
                             (state_d == mci_pkg::BOOT_DONE);
            // Caliptra stays out of reset while the MCU is held
            cptra_rst_b_o <= (state_d == mci_pkg::BOOT_DONE) ||
                             (state_d == mci_pkg::BOOT_MCU_RST);
            hold_cnt_q    <= (state_q == mci_pkg::BOOT_MCU_RST) ? hold_cnt_q + 1'b1 : '0;
        end
    end

endmodule

// ==== verilog/mci_wdt.sv ====
// Two-stage watchdog with 64-bit periods; cascade mode raises the NMI on a second timeout
`timescale 1ns/1ps

module mci_wdt (
    input  logic                             clk,
    input  logic                             rst_i,
    input  logic                             t1_en_i,
    input  logic                             t2_en_i,
    input  logic                             t1_restart_i,
    input  logic                             t2_restart_i,
    input  logic [mci_pkg::WDT_PERIOD_W-1:0] t1_period_i,
    input  logic [mci_pkg::WDT_PERIOD_W-1:0] t2_period_i,
    input  logic                             t1_serviced_i,
    input  logic                             t2_serviced_i,
    output logic                             t1_timeout_o,
    output logic                             t2_timeout_o,
    output logic                             nmi_intr_o
);

    logic [mci_pkg::WDT_PERIOD_W-1:0] t1_cnt_q;
    logic [mci_pkg::WDT_PERIOD_W-1:0] t2_cnt_q;
    logic                             t1_hit;
    logic                             t2_hit;
    logic                             t2_run;

    assign t1_hit = t1_en_i & (t1_cnt_q == t1_period_i);
    // Cascade mode runs stage two only while the first timeout is outstanding
    assign t2_run = t2_en_i | t1_timeout_o;
    assign t2_hit = t2_run & (t2_cnt_q == t2_period_i);

    always_ff @(posedge clk) begin
        if (rst_i || !t1_en_i || t1_restart_i || t1_hit) begin
            t1_cnt_q <= '0;
        end else begin
            t1_cnt_q <= t1_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || !t2_run || t2_restart_i || t2_hit || (!t2_en_i && t1_serviced_i)) begin
            t2_cnt_q <= '0;
        end else begin
            t2_cnt_q <= t2_cnt_q + 1'b1;
        end
    end

    // Sticky status, a timeout wins over a service on the same edge
    always_ff @(posedge clk) begin
        if (rst_i) begin
            t1_timeout_o <= 1'b0;
            t2_timeout_o <= 1'b0;
            nmi_intr_o   <= 1'b0;
        end else begin
            if (t1_hit) t1_timeout_o <= 1'b1;
            else if (t1_serviced_i) t1_timeout_o <= 1'b0;
            if (t2_hit) t2_timeout_o <= 1'b1;
            else if (t2_serviced_i) t2_timeout_o <= 1'b0;
            // NMI only from the cascaded second stage
            if (t2_hit && !t2_en_i) nmi_intr_o <= 1'b1;
            else if (t2_serviced_i) nmi_intr_o <= 1'b0;
        end
    end

endmodule

// ==== verilog/mci_error_intr.sv ====
// Sticky fatal and non-fatal error status and the SoC and MCU interrupt outputs
`timescale 1ns/1ps

module mci_error_intr (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic [mci_pkg::DATA_W-1:0] agg_error_fatal_i,
    input  logic [mci_pkg::DATA_W-1:0] agg_error_non_fatal_i,
    input  logic [mci_pkg::DATA_W-1:0] err_fatal_clr_i,
    input  logic [mci_pkg::DATA_W-1:0] err_non_fatal_clr_i,
    input  logic                       t1_timeout_i,
    input  logic                       nmi_intr_i,
    output logic [mci_pkg::DATA_W-1:0] err_fatal_o,
    output logic [mci_pkg::DATA_W-1:0] err_non_fatal_o,
    output logic                       all_error_fatal_o,
    output logic                       all_error_non_fatal_o,
    output logic                       mci_intr_o
);

    // A new error bit wins over a write-1 clear on the same edge
    always_ff @(posedge clk) begin
        if (rst_i) begin
            err_fatal_o     <= '0;
            err_non_fatal_o <= '0;
        end else begin
            err_fatal_o     <= agg_error_fatal_i | (err_fatal_o & ~err_fatal_clr_i);
            err_non_fatal_o <= agg_error_non_fatal_i | (err_non_fatal_o & ~err_non_fatal_clr_i);
        end
    end

    // SoC facing summaries
    assign all_error_fatal_o     = (|err_fatal_o) | nmi_intr_i;
    assign all_error_non_fatal_o = |err_non_fatal_o;

    // MCU sees non-fatal errors and the first watchdog stage
    assign mci_intr_o = (|err_non_fatal_o) | t1_timeout_i;

endmodule

// ==== verilog/mci_top.sv ====
// MCI top level; ties the register bank, boot sequencer, watchdog and error blocks to the SoC
`timescale 1ns/1ps

module mci_top (
    input  logic                         clk,
    input  logic                         rst_i,
    // Register access port
    input  logic                         req_i,
    input  logic                         write_i,
    input  logic [mci_pkg::ADDR_W-1:0]   addr_i,
    input  logic [mci_pkg::DATA_W-1:0]   wdata_i,
    output logic [mci_pkg::DATA_W-1:0]   rdata_o,
    output logic                         err_o,
    // Lifecycle and fuse controller handshakes
    input  logic                         lc_done_i,
    input  logic                         fc_opt_done_i,
    output logic                         lc_init_o,
    output logic                         fc_opt_init_o,
    // Reset controls
    output logic                         mcu_rst_b_o,
    output logic                         cptra_rst_b_o,
    // Errors and interrupts
    input  logic [mci_pkg::DATA_W-1:0]   agg_error_fatal_i,
    input  logic [mci_pkg::DATA_W-1:0]   agg_error_non_fatal_i,
    output logic                         all_error_fatal_o,
    output logic                         all_error_non_fatal_o,
    output logic                         mci_intr_o,
    output logic                         nmi_intr_o,
    // Generic wires
    input  logic [2*mci_pkg::DATA_W-1:0] generic_in_i,
    output logic [2*mci_pkg::DATA_W-1:0] generic_out_o
);

    logic                             boot_go;
    logic                             mcu_rst_req;
    mci_pkg::boot_state_e             boot_state;
    logic                             t1_en;
    logic                             t2_en;
    logic [mci_pkg::WDT_PERIOD_W-1:0] t1_period;
    logic [mci_pkg::WDT_PERIOD_W-1:0] t2_period;
    logic                             t1_restart;
    logic                             t2_restart;
    logic                             t1_serviced;
    logic                             t2_serviced;
    logic                             t1_timeout;
    logic                             t2_timeout;
    logic [mci_pkg::DATA_W-1:0]       err_fatal;
    logic [mci_pkg::DATA_W-1:0]       err_non_fatal;
    logic [mci_pkg::DATA_W-1:0]       err_fatal_clr;
    logic [mci_pkg::DATA_W-1:0]       err_non_fatal_clr;

    mci_reg_bank i_reg_bank (
        .clk, .rst_i,
        .req_i, .write_i, .addr_i, .wdata_i, .rdata_o, .err_o,
        .generic_in_i, .generic_out_o,
        .boot_state_i        (boot_state),
        .t1_timeout_i        (t1_timeout),
        .t2_timeout_i        (t2_timeout),
        .err_fatal_i         (err_fatal),
        .err_non_fatal_i     (err_non_fatal),
        .boot_go_o           (boot_go),
        .mcu_rst_req_o       (mcu_rst_req),
        .t1_en_o             (t1_en),
        .t2_en_o             (t2_en),
        .t1_period_o         (t1_period),
        .t2_period_o         (t2_period),
        .t1_restart_o        (t1_restart),
        .t2_restart_o        (t2_restart),
        .t1_serviced_o       (t1_serviced),
        .t2_serviced_o       (t2_serviced),
        .err_fatal_clr_o     (err_fatal_clr),
        .err_non_fatal_clr_o (err_non_fatal_clr)
    );

    mci_boot_seqr i_boot_seqr (
        .clk, .rst_i,
        .lc_done_i, .fc_opt_done_i, .lc_init_o, .fc_opt_init_o,
        .mcu_rst_b_o, .cptra_rst_b_o,
        .boot_go_i     (boot_go),
        .mcu_rst_req_i (mcu_rst_req),
        .boot_state_o  (boot_state)
    );

    mci_wdt i_wdt (
        .clk, .rst_i,
        .t1_en_i       (t1_en),
        .t2_en_i       (t2_en),
        .t1_restart_i  (t1_restart),
        .t2_restart_i  (t2_restart),
        .t1_period_i   (t1_period),
        .t2_period_i   (t2_period),
        .t1_serviced_i (t1_serviced),
        .t2_serviced_i (t2_serviced),
        .t1_timeout_o  (t1_timeout),
        .t2_timeout_o  (t2_timeout),
        .nmi_intr_o
    );

    mci_error_intr i_error_intr (
        .clk, .rst_i,
        .agg_error_fatal_i, .agg_error_non_fatal_i,
        .err_fatal_clr_i     (err_fatal_clr),
        .err_non_fatal_clr_i (err_non_fatal_clr),
        .t1_timeout_i        (t1_timeout),
        .nmi_intr_i          (nmi_intr_o),
        .err_fatal_o         (err_fatal),
        .err_non_fatal_o     (err_non_fatal),
        .all_error_fatal_o, .all_error_non_fatal_o, .mci_intr_o
    );

endmodule

// ==== bench/mci_asserts.sv ====
// Concurrent checks on the MCI reset and interrupt outputs, bound into every mci_top
`timescale 1ns/1ps

module mci_asserts (
    input logic clk,
    input logic rst_i,
    input logic lc_init_i,
    input logic fc_opt_init_i,
    input logic mcu_rst_b_i,
    input logic cptra_rst_b_i,
    input logic nmi_intr_i,
    input logic all_error_fatal_i
);

    // Failure count, read by the testbench at the end of the run
    int fail_cnt = 0;

    // Lifecycle and fuse init never overlap
    init_exclusive: assert property (@(posedge clk) disable iff (rst_i)
        !(lc_init_i && fc_opt_init_i))
        else begin
            fail_cnt++;
            $error("lc_init_o and fc_opt_init_o high together");
        end

    // Caliptra only leaves reset after the MCU
    cptra_after_mcu: assert property (@(posedge clk) disable iff (rst_i)
        $rose(cptra_rst_b_i) |-> mcu_rst_b_i)
        else begin
            fail_cnt++;
            $error("cptra_rst_b_o rose while mcu_rst_b_o was low");
        end

    nmi_is_fatal: assert property (@(posedge clk) disable iff (rst_i)
        nmi_intr_i |-> all_error_fatal_i)
        else begin
            fail_cnt++;
            $error("nmi_intr_o high without all_error_fatal_o");
        end

endmodule

bind mci_top mci_asserts u_asserts (
    .clk,
    .rst_i,
    .lc_init_i         (lc_init_o),
    .fc_opt_init_i     (fc_opt_init_o),
    .mcu_rst_b_i       (mcu_rst_b_o),
    .cptra_rst_b_i     (cptra_rst_b_o),
    .nmi_intr_i        (nmi_intr_o),
    .all_error_fatal_i (all_error_fatal_o)
);

// ==== bench/mci_tb.sv ====
// Directed testbench for mci_top; compile with sources.f and run mci_tb as the top module
`timescale 1ns/1ps

module mci_tb;

    // The directed tests finish in well under 1500 cycles
    localparam int TIMEOUT_CYCLES = 5000;
    localparam int CLK_HALF_NS    = 4;

    logic                         clk;
    logic                         rst_i;
    logic                         req_i;
    logic                         write_i;
    logic [mci_pkg::ADDR_W-1:0]   addr_i;
    logic [mci_pkg::DATA_W-1:0]   wdata_i;
    logic [mci_pkg::DATA_W-1:0]   rdata_o;
    logic                         err_o;
    logic                         lc_done_i;
    logic                         fc_opt_done_i;
    logic                         lc_init_o;
    logic                         fc_opt_init_o;
    logic                         mcu_rst_b_o;
    logic                         cptra_rst_b_o;
    logic [mci_pkg::DATA_W-1:0]   agg_error_fatal_i;
    logic [mci_pkg::DATA_W-1:0]   agg_error_non_fatal_i;
    logic                         all_error_fatal_o;
    logic                         all_error_non_fatal_o;
    logic                         mci_intr_o;
    logic                         nmi_intr_o;
    logic [2*mci_pkg::DATA_W-1:0] generic_in_i;
    logic [2*mci_pkg::DATA_W-1:0] generic_out_o;
    int                           seed = 32'hae5a;
    int                           cycle_cnt = 0;

    mci_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #CLK_HALF_NS clk = ~clk;
    end

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1, "Run stopped at the first failure");
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests were still running after %0d cycles", cycle_cnt);
            abort_run();
        end
    end

    task automatic check_word(input string name, input logic [mci_pkg::DATA_W-1:0] actual,
                              input logic [mci_pkg::DATA_W-1:0] expected);
        if (actual !== expected) begin
            $display("Error: %s = %h, expected %h", name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("Error: %s = %h, expected %h", name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_state(input string name, input mci_pkg::boot_state_e actual,
                               input mci_pkg::boot_state_e expected);
        if (actual !== expected) begin
            $display("Error: %s = %h, expected %h", name, actual, expected);
            abort_run();
        end
    endtask

    // One clock, then settle just past the edge where inputs change
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic reg_write(input logic [mci_pkg::ADDR_W-1:0] addr,
                             input logic [mci_pkg::DATA_W-1:0] data);
        req_i   = 1'b1;
        write_i = 1'b1;
        addr_i  = addr;
        wdata_i = data;
        step();
        req_i   = 1'b0;
        write_i = 1'b0;
    endtask

    task automatic reg_read(input logic [mci_pkg::ADDR_W-1:0] addr,
                            output logic [mci_pkg::DATA_W-1:0] data, output logic err);
        req_i   = 1'b1;
        write_i = 1'b0;
        addr_i  = addr;
        step();
        req_i = 1'b0;
        data  = rdata_o;
        err   = err_o;
    endtask

    task automatic read_expect(input logic [mci_pkg::ADDR_W-1:0] addr, input string reg_name,
                               input logic [mci_pkg::DATA_W-1:0] expected);
        logic [mci_pkg::DATA_W-1:0] data;
        logic                       err;
        reg_read(addr, data, err);
        check_bit({"err_o reading ", reg_name}, err, 1'b0);
        check_word({"rdata_o reading ", reg_name}, data, expected);
    endtask

    task automatic expect_boot_state(input mci_pkg::boot_state_e expected);
        logic [mci_pkg::DATA_W-1:0] data;
        logic                       err;
        reg_read(mci_pkg::REG_BOOT_STATUS, data, err);
        check_state("rdata_o boot state", mci_pkg::boot_state_e'(data[2:0]), expected);
    endtask

    task automatic test_boot();
        int n;
        // Lifecycle init starts on the first cycle out of reset
        step();
        check_bit("lc_init_o", lc_init_o, 1'b1);
        check_bit("fc_opt_init_o", fc_opt_init_o, 1'b0);
        repeat (3) step();
        check_bit("lc_init_o", lc_init_o, 1'b1);
        lc_done_i = 1'b1;
        step();
        lc_done_i = 1'b0;
        check_bit("lc_init_o", lc_init_o, 1'b0);
        check_bit("fc_opt_init_o", fc_opt_init_o, 1'b1);
        repeat (3) step();
        check_bit("fc_opt_init_o", fc_opt_init_o, 1'b1);
        check_bit("mcu_rst_b_o", mcu_rst_b_o, 1'b0);
        fc_opt_done_i = 1'b1;
        step();
        fc_opt_done_i = 1'b0;
        check_bit("fc_opt_init_o", fc_opt_init_o, 1'b0);
        check_bit("mcu_rst_b_o", mcu_rst_b_o, 1'b1);
        expect_boot_state(mci_pkg::BOOT_WAIT_GO);
        check_bit("cptra_rst_b_o", cptra_rst_b_o, 1'b0);
        reg_write(mci_pkg::REG_BOOT_GO, 32'd1);
        // Caliptra released within two cycles of the write
        n = 0;
        while (!cptra_rst_b_o && n < 2) begin
            step();
            n++;
        end
        check_bit("cptra_rst_b_o", cptra_rst_b_o, 1'b1);
        expect_boot_state(mci_pkg::BOOT_DONE);
    endtask

    task automatic test_regs();
        logic [mci_pkg::DATA_W-1:0] lo;
        logic [mci_pkg::DATA_W-1:0] hi;
        logic                       err;
        lo = $random(seed);
        hi = $random(seed);
        reg_write(mci_pkg::REG_GENERIC_OUT0, lo);
        reg_write(mci_pkg::REG_GENERIC_OUT1, hi);
        check_word("generic_out_o[31:0]", generic_out_o[31:0], lo);
        check_word("generic_out_o[63:32]", generic_out_o[63:32], hi);
        read_expect(mci_pkg::REG_GENERIC_OUT0, "GENERIC_OUT0", lo);
        read_expect(mci_pkg::REG_GENERIC_OUT1, "GENERIC_OUT1", hi);
        lo = $random(seed);
        hi = $random(seed);
        generic_in_i = {hi, lo};
        read_expect(mci_pkg::REG_GENERIC_IN0, "GENERIC_IN0", lo);
        read_expect(mci_pkg::REG_GENERIC_IN1, "GENERIC_IN1", hi);
        // Unmapped offset
        reg_read(12'h07C, lo, err);
        check_bit("err_o", err, 1'b1);
        check_word("rdata_o", lo, 32'h0);
    endtask

    task automatic test_errors();
        logic [mci_pkg::DATA_W-1:0] fat;
        logic [mci_pkg::DATA_W-1:0] nf;
        logic [mci_pkg::DATA_W-1:0] mask;
        fat  = $random(seed) | 32'h1;
        nf   = $random(seed) | 32'h1;
        mask = $random(seed);
        agg_error_fatal_i     = fat;
        agg_error_non_fatal_i = nf;
        step();
        agg_error_fatal_i     = '0;
        agg_error_non_fatal_i = '0;
        check_bit("all_error_fatal_o", all_error_fatal_o, 1'b1);
        check_bit("all_error_non_fatal_o", all_error_non_fatal_o, 1'b1);
        check_bit("mci_intr_o", mci_intr_o, 1'b1);
        read_expect(mci_pkg::REG_ERR_FATAL, "ERR_FATAL", fat);
        read_expect(mci_pkg::REG_ERR_NON_FATAL, "ERR_NON_FATAL", nf);
        // Partial write-1 clears
        reg_write(mci_pkg::REG_ERR_FATAL, mask);
        read_expect(mci_pkg::REG_ERR_FATAL, "ERR_FATAL", fat & ~mask);
        check_bit("all_error_fatal_o", all_error_fatal_o, |(fat & ~mask));
        reg_write(mci_pkg::REG_ERR_NON_FATAL, mask);
        read_expect(mci_pkg::REG_ERR_NON_FATAL, "ERR_NON_FATAL", nf & ~mask);
        check_bit("mci_intr_o", mci_intr_o, |(nf & ~mask));
        // A new error beats a clear on the same edge
        agg_error_fatal_i = 32'h8000_0000;
        reg_write(mci_pkg::REG_ERR_FATAL, 32'hFFFF_FFFF);
        agg_error_fatal_i = '0;
        read_expect(mci_pkg::REG_ERR_FATAL, "ERR_FATAL", 32'h8000_0000);
        reg_write(mci_pkg::REG_ERR_FATAL, 32'hFFFF_FFFF);
        reg_write(mci_pkg::REG_ERR_NON_FATAL, 32'hFFFF_FFFF);
        check_bit("all_error_fatal_o", all_error_fatal_o, 1'b0);
        check_bit("all_error_non_fatal_o", all_error_non_fatal_o, 1'b0);
        check_bit("mci_intr_o", mci_intr_o, 1'b0);
    endtask

    task automatic test_wdt();
        logic [mci_pkg::DATA_W-1:0] status;
        logic                       err;
        int                         n;
        // Cascade mode, t1 period 20 and t2 period 30
        reg_write(mci_pkg::REG_WDT_T1_PERIOD0, 32'd20);
        reg_write(mci_pkg::REG_WDT_T2_PERIOD0, 32'd30);
        reg_write(mci_pkg::REG_WDT_T1_EN, 32'd1);
        n = 0;
        while (!mci_intr_o && n < 23) begin
            step();
            n++;
        end
        check_bit("mci_intr_o", mci_intr_o, 1'b1);
        check_bit("nmi_intr_o", nmi_intr_o, 1'b0);
        read_expect(mci_pkg::REG_WDT_STATUS, "WDT_STATUS", 32'h1);
        n = 0;
        while (!nmi_intr_o && n < 33) begin
            step();
            n++;
        end
        check_bit("nmi_intr_o", nmi_intr_o, 1'b1);
        check_bit("all_error_fatal_o", all_error_fatal_o, 1'b1);
        read_expect(mci_pkg::REG_WDT_STATUS, "WDT_STATUS", 32'h3);
        reg_write(mci_pkg::REG_WDT_T1_EN, 32'd0);
        reg_write(mci_pkg::REG_WDT_STATUS, 32'h3);
        read_expect(mci_pkg::REG_WDT_STATUS, "WDT_STATUS", 32'h0);
        check_bit("nmi_intr_o", nmi_intr_o, 1'b0);
        check_bit("all_error_fatal_o", all_error_fatal_o, 1'b0);
        check_bit("mci_intr_o", mci_intr_o, 1'b0);
        // Independent mode, no NMI from timer 2
        reg_write(mci_pkg::REG_WDT_T2_EN, 32'd1);
        n      = 0;
        status = '0;
        while (!status[1] && n < 34) begin
            reg_read(mci_pkg::REG_WDT_STATUS, status, err);
            n++;
        end
        check_word("rdata_o reading WDT_STATUS", status, 32'h2);
        check_bit("nmi_intr_o", nmi_intr_o, 1'b0);
        reg_write(mci_pkg::REG_WDT_T2_EN, 32'd0);
        reg_write(mci_pkg::REG_WDT_STATUS, 32'h2);
        read_expect(mci_pkg::REG_WDT_STATUS, "WDT_STATUS", 32'h0);
    endtask

    task automatic test_mcu_reset();
        int n;
        reg_write(mci_pkg::REG_RESET_REQUEST, 32'd1);
        check_bit("mcu_rst_b_o", mcu_rst_b_o, 1'b0);
        n = 0;
        while (!mcu_rst_b_o && n <= mci_pkg::MCU_RST_HOLD_CYCLES) begin
            check_bit("cptra_rst_b_o", cptra_rst_b_o, 1'b1);
            step();
            n++;
        end
        check_word("mcu_rst_b_o low cycles", n, mci_pkg::MCU_RST_HOLD_CYCLES);
        expect_boot_state(mci_pkg::BOOT_DONE);
    endtask

    initial begin
        rst_i                 = 1'b1;
        req_i                 = 1'b0;
        write_i               = 1'b0;
        addr_i                = '0;
        wdata_i               = '0;
        lc_done_i             = 1'b0;
        fc_opt_done_i         = 1'b0;
        agg_error_fatal_i     = '0;
        agg_error_non_fatal_i = '0;
        generic_in_i          = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_i = 1'b0;
        // Reset values
        check_bit("mcu_rst_b_o", mcu_rst_b_o, 1'b0);
        check_bit("cptra_rst_b_o", cptra_rst_b_o, 1'b0);
        check_bit("fc_opt_init_o", fc_opt_init_o, 1'b0);
        check_bit("nmi_intr_o", nmi_intr_o, 1'b0);
        check_bit("all_error_fatal_o", all_error_fatal_o, 1'b0);
        check_bit("all_error_non_fatal_o", all_error_non_fatal_o, 1'b0);
        check_bit("mci_intr_o", mci_intr_o, 1'b0);
        check_bit("err_o", err_o, 1'b0);
        check_bit("generic_out_o any bit", |generic_out_o, 1'b0);
        test_boot();
        test_regs();
        test_errors();
        test_wdt();
        test_mcu_reset();
        if (uut.u_asserts.fail_cnt == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("Concurrent assertions failed %0d times", uut.u_asserts.fail_cnt);
            abort_run();
        end
    end

endmodule

// ==== sources.f ====
verilog/mci_pkg.sv
verilog/mci_reg_bank.sv
verilog/mci_boot_seqr.sv
verilog/mci_wdt.sv
verilog/mci_error_intr.sv
verilog/mci_top.sv
bench/mci_asserts.sv
bench/mci_tb.sv

// ==== Makefile ====
TOP = mci_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f sources.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
